// File: project.f
+incdir+source
source/core_bus_pkg.sv
source/fetch_port.sv
source/lsu_port.sv
source/bus_arbiter.sv
source/axi_master.sv
source/core_top.sv
sim/axi_slave_model.sv
sim/tb_core_top.sv

// File: Bender.yml
package:
  name: core_bus_shell

sources:
  - include_dirs:
      - source
    files:
      - source/core_bus_pkg.sv
      - source/fetch_port.sv
      - source/lsu_port.sv
      - source/bus_arbiter.sv
      - source/axi_master.sv
      - source/core_top.sv
  - target: simulation
    files:
      - sim/axi_slave_model.sv
      - sim/tb_core_top.sv

// File: sim/tb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_top import core_bus_pkg::*; ();

  localparam int wait_limit = 100;

  logic      aclk;
  logic      rst;
  addr_t     pc;
  logic      fetch_valid;
  logic      fetch_ready;
  word_t     instr;
  logic      instr_valid;
  logic      instr_err;
  addr_t     ls_addr;
  logic      ls_write;
  mem_size_e ls_size;
  logic      ls_signed;
  word_t     ls_wdata;
  logic      ls_valid;
  logic      ls_ready;
  word_t     ls_rdata;
  logic      ls_done;
  logic      ls_err;
  axi_id_t   arid, rid, awid, wid, bid;
  addr_t     araddr, awaddr;
  logic [7:0] arlen, awlen;
  logic [2:0] arsize, awsize, arprot, awprot;
  logic [1:0] arburst, awburst, arlock, awlock;
  logic [3:0] arcache, awcache;
  logic      arvalid, arready, rvalid, rready, rlast;
  logic      awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  word_t     rdata, wdata;
  strb_t     wstrb;
  axi_resp_t rresp, bresp;

  word_t mirror [0:255];  // expected memory contents
  int    errors;
  int    tests_run;
  int    tests_failed;

  core_top UUT (.*);

  axi_slave_model u_mem (.*);

  initial aclk = 1'b0;
  always #4 aclk = ~aclk;

  task automatic next_cycle;
    @(posedge aclk);
    #1;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // single beat incr bursts, normal access, readies tied high
  always @(negedge aclk) begin
    if (!rst) begin
      check_err("rready", rready, 1'b1);
      check_err("bready", bready, 1'b1);
      check_word("wid", word_t'(wid), 32'd0);
      if (arvalid === 1'b1) begin
        check_word("arlen", word_t'(arlen), 32'd0);
        check_word("arsize", word_t'(arsize), 32'd2);
        check_word("arburst", word_t'(arburst), 32'd1);
        check_word("arlock", word_t'(arlock), 32'd0);
        check_word("arcache", word_t'(arcache), 32'd0);
        check_word("arprot", word_t'(arprot), 32'd0);
      end
      if (awvalid === 1'b1) begin
        check_word("awlen", word_t'(awlen), 32'd0);
        check_word("awsize", word_t'(awsize), 32'd2);
        check_word("awburst", word_t'(awburst), 32'd1);
        check_word("awlock", word_t'(awlock), 32'd0);
        check_word("awcache", word_t'(awcache), 32'd0);
        check_word("awprot", word_t'(awprot), 32'd0);
      end
      if (wvalid === 1'b1) begin
        check_err("wlast", wlast, 1'b1);
      end
    end
  end

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors > errors_before) begin
      tests_failed++;
      $display("[fail] %s, %0d errors", name, errors - errors_before);
    end else begin
      $display("[ok]   %s", name);
    end
  endtask

  // byte lanes picked by size and low address bits
  function automatic void apply_store(addr_t a, mem_size_e sz, word_t d);
    int   lane;
    logic hit;
    if (a >= 32'h400) return;
    for (lane = 0; lane < 4; lane++) begin
      case (sz)
        size_byte: hit = (lane == a[1:0]);
        size_half: hit = ((lane / 2) == a[1]);
        default:   hit = 1'b1;
      endcase
      if (hit) begin
        case (sz)
          size_byte: mirror[a[9:2]][8*lane +: 8] = d[7:0];
          size_half: mirror[a[9:2]][8*lane +: 8] = d[8*(lane % 2) +: 8];
          default:   mirror[a[9:2]][8*lane +: 8] = d[8*lane +: 8];
        endcase
      end
    end
  endfunction

  function automatic word_t load_expect(word_t w, logic [1:0] off, mem_size_e sz, logic sgn);
    word_t field;
    case (sz)
      size_byte: begin
        field = word_t'(w[8*off +: 8]);
        if (sgn && field[7]) field = field | 32'hffff_ff00;
      end
      size_half: begin
        field = word_t'(w[16*off[1] +: 16]);
        if (sgn && field[15]) field = field | 32'hffff_0000;
      end
      default: field = w;
    endcase
    return field;
  endfunction

  task automatic fetch_access(input addr_t a, output word_t data, output logic err);
    int n;
    n = 0;
    while (!fetch_ready && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (!fetch_ready) begin
      $display("fetch port stayed busy before fetch at %h", a);
      errors++;
      data = 'x;
      err  = 1'bx;
      return;
    end
    pc          = a;
    fetch_valid = 1'b1;
    next_cycle();
    fetch_valid = 1'b0;
    n = 0;
    while (!instr_valid && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (!instr_valid) begin
      $display("timed out waiting for instr_valid, fetch at %h", a);
      errors++;
    end
    data = instr;
    err  = instr_err;
  endtask

  task automatic ls_access(input addr_t a, input logic wr, input mem_size_e sz,
                           input logic sgn, input word_t wd, output word_t rd,
                           output logic err);
    int n;
    n = 0;
    while (!ls_ready && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (!ls_ready) begin
      $display("load/store port stayed busy before access at %h", a);
      errors++;
      rd  = 'x;
      err = 1'bx;
      return;
    end
    ls_addr   = a;
    ls_write  = wr;
    ls_size   = sz;
    ls_signed = sgn;
    ls_wdata  = wd;
    ls_valid  = 1'b1;
    next_cycle();
    ls_valid = 1'b0;
    n = 0;
    while (!ls_done && n < wait_limit) begin
      next_cycle();
      n++;
    end
    if (!ls_done) begin
      $display("timed out waiting for ls_done, access at %h", a);
      errors++;
    end
    rd  = ls_rdata;
    err = ls_err;
  endtask

  task automatic store_and_check(input addr_t a, input mem_size_e sz, input word_t d);
    word_t rd;
    logic  err;
    ls_access(a, 1'b1, sz, 1'b0, d, rd, err);
    check_err("ls_err", err, 1'b0);
    apply_store(a, sz, d);
  endtask

  task automatic load_and_check(input addr_t a, input mem_size_e sz, input logic sgn);
    word_t rd;
    logic  err;
    ls_access(a, 1'b0, sz, sgn, '0, rd, err);
    check_word("ls_rdata", rd, load_expect(mirror[a[9:2]], a[1:0], sz, sgn));
    check_err("ls_err", err, 1'b0);
  endtask

  task automatic reset_outputs;
    int start;
    start = errors;
    next_cycle();  // reset reaches the blocks one cycle late
    check_err("arvalid", arvalid, 1'b0);
    check_err("awvalid", awvalid, 1'b0);
    check_err("wvalid", wvalid, 1'b0);
    check_err("instr_valid", instr_valid, 1'b0);
    check_err("ls_done", ls_done, 1'b0);
    check_err("fetch_ready", fetch_ready, 1'b1);
    check_err("ls_ready", ls_ready, 1'b1);
    report_test("reset", start);
  endtask

  task automatic fetch_preloaded;
    int    start;
    int    k;
    addr_t a;
    word_t data;
    logic  err;
    start = errors;
    for (k = 0; k < 8; k++) begin
      a = (addr_t'($urandom_range(255, 0)) << 2) | addr_t'($urandom_range(3, 0));
      fetch_access(a, data, err);
      check_word("instr", data, mirror[a[9:2]]);
      check_err("instr_err", err, 1'b0);
    end
    report_test("fetch", start);
  endtask

  task automatic stores_by_size;
    int    start;
    int    k;
    addr_t a;
    start = errors;
    for (k = 0; k < 9; k++) begin
      a = addr_t'($urandom_range(255, 0)) << 2;
      case (k % 3)
        0: a = a | addr_t'($urandom_range(3, 0));
        1: a = a | (addr_t'($urandom_range(1, 0)) << 1);
        default: a = a;
      endcase
      store_and_check(a, mem_size_e'(k % 3), $urandom);
      load_and_check({a[31:2], 2'b00}, size_word, 1'b0);  // whole word after the store
    end
    report_test("stores", start);
  endtask

  task automatic loads_by_offset;
    int    start;
    int    base;
    int    off;
    int    sgn;
    start = errors;
    store_and_check(32'h100, size_word, 32'h80ff_7f01);  // both sign cases per lane
    store_and_check(32'h104, size_word, $urandom);
    for (base = 32'h100; base <= 32'h104; base += 4) begin
      for (off = 0; off < 4; off++) begin
        for (sgn = 0; sgn < 2; sgn++) begin
          load_and_check(addr_t'(base + off), size_byte, sgn[0]);
          if (off % 2 == 0) load_and_check(addr_t'(base + off), size_half, sgn[0]);
        end
      end
    end
    report_test("loads", start);
  endtask

  task automatic shared_access;
    int    start;
    int    round;
    int    n;
    int    idx_f;
    int    idx_l;
    logic  got_f;
    logic  got_l;
    start = errors;
    for (round = 0; round < 6; round++) begin
      idx_f = $urandom_range(255, 0);
      idx_l = $urandom_range(255, 0);
      n = 0;
      while (!(fetch_ready && ls_ready) && n < wait_limit) begin
        next_cycle();
        n++;
      end
      if (!(fetch_ready && ls_ready)) begin
        $display("ports stayed busy before round %0d", round);
        errors++;
      end
      pc          = addr_t'(idx_f) << 2;
      fetch_valid = 1'b1;
      ls_addr     = addr_t'(idx_l) << 2;
      ls_write    = 1'b0;
      ls_size     = size_word;
      ls_signed   = 1'b0;
      ls_valid    = 1'b1;
      next_cycle();
      fetch_valid = 1'b0;
      ls_valid    = 1'b0;
      got_f = 1'b0;
      got_l = 1'b0;
      n = 0;
      while (!(got_f && got_l) && n < wait_limit) begin
        if (instr_valid && !got_f) begin
          got_f = 1'b1;
          check_word("instr", instr, mirror[idx_f]);
          check_err("instr_err", instr_err, 1'b0);
        end
        if (ls_done && !got_l) begin
          got_l = 1'b1;
          check_word("ls_rdata", ls_rdata, mirror[idx_l]);
          check_err("ls_err", ls_err, 1'b0);
        end
        next_cycle();
        n++;
      end
      if (!(got_f && got_l)) begin
        $display("timed out waiting for both responses in round %0d", round);
        errors++;
      end
    end
    report_test("sharing", start);
  endtask

  task automatic error_responses;
    int    start;
    word_t data;
    logic  err;
    start = errors;
    fetch_access(32'h800, data, err);
    check_err("instr_err", err, 1'b1);
    ls_access(32'ha04, 1'b0, size_word, 1'b0, '0, data, err);
    check_err("ls_err", err, 1'b1);
    ls_access(32'h900, 1'b1, size_word, 1'b0, 32'h1234_5678, data, err);
    check_err("ls_err", err, 1'b1);
    report_test("errors", start);
  endtask

  initial begin
    int i;
    void'($urandom(49381));
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst          = 1'b1;
    pc           = '0;
    fetch_valid  = 1'b0;
    ls_addr      = '0;
    ls_write     = 1'b0;
    ls_size      = size_word;
    ls_signed    = 1'b0;
    ls_wdata     = '0;
    ls_valid     = 1'b0;
    for (i = 0; i < 256; i++) begin
      mirror[i]      = $urandom;
      u_mem.words[i] = mirror[i];
    end
    repeat (3) @(posedge aclk);
    #1;
    rst = 1'b0;
    reset_outputs();
    fetch_preloaded();
    stores_by_size();
    loads_by_offset();
    shared_access();
    error_responses();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_slave_model import core_bus_pkg::*; (
  input  logic      aclk,
  input  logic      rst,
  input  axi_id_t   arid,
  input  addr_t     araddr,
  input  logic      arvalid,
  output logic      arready,
  output axi_id_t   rid,
  output word_t     rdata,
  output axi_resp_t rresp,
  output logic      rlast,
  output logic      rvalid,
  input  axi_id_t   awid,
  input  addr_t     awaddr,
  input  logic      awvalid,
  output logic      awready,
  input  word_t     wdata,
  input  strb_t     wstrb,
  input  logic      wvalid,
  output logic      wready,
  output axi_id_t   bid,
  output axi_resp_t bresp,
  output logic      bvalid
);

  localparam addr_t err_base = 32'h0000_0800;  // slverr from here up

  word_t words [0:255];  // 1 KiB, filled by the testbench

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge aclk);
      #1;
    end
  endtask

  task automatic serve_read;
    addr_t   a;
    axi_id_t id;
    idle_cycles($urandom_range(3, 0));
    arready = 1'b1;
    a       = araddr;  // held stable while arvalid waits
    id      = arid;
    idle_cycles(1);
    arready = 1'b0;
    idle_cycles($urandom_range(3, 0));
    rid    = id;
    rresp  = (a >= err_base) ? 2'b10 : 2'b00;
    rdata  = (a >= err_base) ? '0 : words[a[9:2]];
    rvalid = 1'b1;
    idle_cycles(1);  // master keeps rready high
    rvalid = 1'b0;
  endtask

  task automatic serve_write;
    addr_t   a;
    axi_id_t id;
    word_t   d;
    strb_t   s;
    int      lane;
    idle_cycles($urandom_range(3, 0));
    awready = 1'b1;
    wready  = 1'b1;
    a       = awaddr;
    id      = awid;
    d       = wdata;
    s       = wstrb;
    idle_cycles(1);
    awready = 1'b0;
    wready  = 1'b0;
    if (a < err_base) begin
      for (lane = 0; lane < 4; lane++) begin
        if (s[lane]) words[a[9:2]][8*lane +: 8] = d[8*lane +: 8];
      end
    end
    idle_cycles($urandom_range(3, 0));
    bid    = id;
    bresp  = (a >= err_base) ? 2'b10 : 2'b00;
    bvalid = 1'b1;
    idle_cycles(1);
    bvalid = 1'b0;
  endtask

  // one transaction at a time, reads first
  initial begin
    arready = 1'b0;
    rid     = '0;
    rdata   = '0;
    rresp   = 2'b00;
    rlast   = 1'b1;
    rvalid  = 1'b0;
    awready = 1'b0;
    wready  = 1'b0;
    bid     = '0;
    bresp   = 2'b00;
    bvalid  = 1'b0;
    forever begin
      @(posedge aclk);
      #1;
      if (!rst && arvalid) serve_read();
      else if (!rst && awvalid && wvalid) serve_write();
    end
  end

endmodule

`default_nettype wire

// File: source/core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_params.svh"

module core_top import core_bus_pkg::*; (
  input  logic                  aclk,
  input  logic                  rst,
  // instruction fetch
  input  addr_t                 pc,
  input  logic                  fetch_valid,
  output logic                  fetch_ready,
  output word_t                 instr,
  output logic                  instr_valid,
  output logic                  instr_err,
  // load/store
  input  addr_t                 ls_addr,
  input  logic                  ls_write,
  input  mem_size_e             ls_size,
  input  logic                  ls_signed,
  input  word_t                 ls_wdata,
  input  logic                  ls_valid,
  output logic                  ls_ready,
  output word_t                 ls_rdata,
  output logic                  ls_done,
  output logic                  ls_err,
  // axi read address
  output logic [`AXI_ID_W-1:0]  arid,
  output logic [`AXI_ADDR_W-1:0] araddr,
  output logic [7:0]            arlen,
  output logic [2:0]            arsize,
  output logic [1:0]            arburst,
  output logic [1:0]            arlock,
  output logic [3:0]            arcache,
  output logic [2:0]            arprot,
  output logic                  arvalid,
  input  logic                  arready,
  // axi read data
  input  logic [`AXI_ID_W-1:0]  rid,
  input  logic [`AXI_DATA_W-1:0] rdata,
  input  logic [1:0]            rresp,
  input  logic                  rlast,
  input  logic                  rvalid,
  output logic                  rready,
  // axi write address
  output logic [`AXI_ID_W-1:0]  awid,
  output logic [`AXI_ADDR_W-1:0] awaddr,
  output logic [7:0]            awlen,
  output logic [2:0]            awsize,
  output logic [1:0]            awburst,
  output logic [1:0]            awlock,
  output logic [3:0]            awcache,
  output logic [2:0]            awprot,
  output logic                  awvalid,
  input  logic                  awready,
  // axi write data
  output logic [`AXI_ID_W-1:0]  wid,
  output logic [`AXI_DATA_W-1:0] wdata,
  output logic [`AXI_DATA_W/8-1:0] wstrb,
  output logic                  wlast,
  output logic                  wvalid,
  input  logic                  wready,
  // axi write response
  input  logic [`AXI_ID_W-1:0]  bid,
  input  logic [1:0]            bresp,
  input  logic                  bvalid,
  output logic                  bready
);

  logic     rst_q;
  bus_req_t f_req, l_req, m_req;
  logic     f_req_valid, f_req_ready, l_req_valid, l_req_ready;
  bus_rsp_t f_rsp, l_rsp, m_rsp;
  logic     f_rsp_valid, l_rsp_valid, m_rsp_valid;
  axi_id_t  m_id, m_rsp_id;
  logic     m_valid, m_ready;
  axi_ar_t  ar;
  axi_aw_t  aw;
  axi_w_t   w;
  axi_r_t   r;
  axi_b_t   b;

  always_ff @(posedge aclk) rst_q <= rst;  // blocks see reset one cycle late

  fetch_port u_fetch (
    .aclk, .rst(rst_q), .pc, .fetch_valid, .fetch_ready, .instr, .instr_valid, .instr_err,
    .req(f_req), .req_valid(f_req_valid), .req_ready(f_req_ready),
    .rsp(f_rsp), .rsp_valid(f_rsp_valid)
  );

  lsu_port u_lsu (
    .aclk, .rst(rst_q), .ls_addr, .ls_write, .ls_size, .ls_signed, .ls_wdata, .ls_valid,
    .ls_ready, .ls_rdata, .ls_done, .ls_err,
    .req(l_req), .req_valid(l_req_valid), .req_ready(l_req_ready),
    .rsp(l_rsp), .rsp_valid(l_rsp_valid)
  );

  bus_arbiter u_arb (
    .aclk, .rst(rst_q),
    .req_f(f_req), .req_f_valid(f_req_valid), .req_f_ready(f_req_ready),
    .req_l(l_req), .req_l_valid(l_req_valid), .req_l_ready(l_req_ready),
    .rsp_f(f_rsp), .rsp_f_valid(f_rsp_valid), .rsp_l(l_rsp), .rsp_l_valid(l_rsp_valid),
    .m_req, .m_id, .m_valid, .m_ready, .m_rsp, .m_rsp_id, .m_rsp_valid
  );

  axi_master u_master (
    .aclk, .rst(rst_q),
    .m_req, .m_id, .m_valid, .m_ready, .m_rsp, .m_rsp_id, .m_rsp_valid,
    .ar, .ar_valid(arvalid), .ar_ready(arready),
    .aw, .aw_valid(awvalid), .aw_ready(awready),
    .w, .w_valid(wvalid), .w_ready(wready),
    .r, .r_valid(rvalid), .r_ready(rready),
    .b, .b_valid(bvalid), .b_ready(bready)
  );

  assign arid    = ar.id;
  assign araddr  = ar.addr;
  assign arlen   = ar.len;
  assign arsize  = ar.size;
  assign arburst = ar.burst;
  assign arlock  = ar.lock;
  assign arcache = ar.cache;
  assign arprot  = ar.prot;
  assign awid    = aw.id;
  assign awaddr  = aw.addr;
  assign awlen   = aw.len;
  assign awsize  = aw.size;
  assign awburst = aw.burst;
  assign awlock  = aw.lock;
  assign awcache = aw.cache;
  assign awprot  = aw.prot;
  assign wid     = '0;
  assign wdata   = w.data;
  assign wstrb   = w.strb;
  assign wlast   = w.last;

  assign r.id   = rid;
  assign r.data = rdata;
  assign r.resp = rresp;
  assign r.last = rlast;
  assign b.id   = bid;
  assign b.resp = bresp;

endmodule

`default_nettype wire

// File: source/axi_master.sv
`timescale 1ns/1ps
`default_nettype none

module axi_master import core_bus_pkg::*; (
  input  logic     aclk,
  input  logic     rst,
  input  bus_req_t m_req,
  input  axi_id_t  m_id,
  input  logic     m_valid,
  output logic     m_ready,
  output bus_rsp_t m_rsp,
  output axi_id_t  m_rsp_id,
  output logic     m_rsp_valid,
  output axi_ar_t  ar,
  output logic     ar_valid,
  input  logic     ar_ready,
  output axi_aw_t  aw,
  output logic     aw_valid,
  input  logic     aw_ready,
  output axi_w_t   w,
  output logic     w_valid,
  input  logic     w_ready,
  input  axi_r_t   r,
  input  logic     r_valid,
  output logic     r_ready,
  input  axi_b_t   b,
  input  logic     b_valid,
  output logic     b_ready
);

  typedef enum logic [1:0] {idle, addr_rd, addr_wr} state_e;

  state_e state;
  axi_b_t b_hold;      // b that collided with r
  logic   b_hold_valid;

  // single beat incr burst, full word
  function automatic axi_ar_t make_addr(addr_t addr, axi_id_t id);
    axi_ar_t a;
    a.id    = id;
    a.addr  = addr;
    a.len   = 8'd0;
    a.size  = 3'd2;
    a.burst = 2'b01;
    a.lock  = 2'b00;
    a.cache = 4'b0000;
    a.prot  = 3'b000;
    return a;
  endfunction

  assign m_ready = (state == idle);
  assign r_ready = 1'b1;
  assign b_ready = 1'b1;

  always_ff @(posedge aclk) begin
    if (rst) begin
      state    <= idle;
      ar_valid <= 1'b0;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else begin
      case (state)
        idle: if (m_valid) begin
          if (m_req.write) begin
            aw_valid <= 1'b1;
            w_valid  <= 1'b1;
            state    <= addr_wr;
          end else begin
            ar_valid <= 1'b1;
            state    <= addr_rd;
          end
        end
        addr_rd: if (ar_ready) begin
          ar_valid <= 1'b0;
          state    <= idle;
        end
        addr_wr: begin
          if (aw_ready) aw_valid <= 1'b0;
          if (w_ready) w_valid <= 1'b0;
          if ((!aw_valid || aw_ready) && (!w_valid || w_ready)) state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (state == idle && m_valid) begin
      ar     <= make_addr(m_req.addr, m_id);
      aw     <= make_addr(m_req.addr, m_id);
      w.data <= m_req.wdata;
      w.strb <= m_req.wstrb;
      w.last <= 1'b1;
    end
  end

  // r first, a colliding b waits one cycle
  always_ff @(posedge aclk) begin
    if (rst) begin
      m_rsp_valid  <= 1'b0;
      b_hold_valid <= 1'b0;
    end else begin
      m_rsp_valid <= r_valid || b_valid || b_hold_valid;
      if (r_valid) begin
        b_hold_valid <= b_valid || b_hold_valid;
      end else begin
        b_hold_valid <= b_hold_valid && b_valid;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (r_valid) begin
      m_rsp.rdata <= r.data;
      m_rsp.err   <= (r.resp != 2'b00);
      m_rsp_id    <= r.id;
      if (b_valid) b_hold <= b;
    end else if (b_hold_valid) begin
      m_rsp.rdata <= '0;
      m_rsp.err   <= (b_hold.resp != 2'b00);
      m_rsp_id    <= b_hold.id;
      if (b_valid) b_hold <= b;
    end else if (b_valid) begin
      m_rsp.rdata <= '0;  // writes return no data
      m_rsp.err   <= (b.resp != 2'b00);
      m_rsp_id    <= b.id;
    end
  end

endmodule

`default_nettype wire

// File: source/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_params.svh"

module bus_arbiter import core_bus_pkg::*; (
  input  logic     aclk,
  input  logic     rst,
  input  bus_req_t req_f,
  input  logic     req_f_valid,
  output logic     req_f_ready,
  input  bus_req_t req_l,
  input  logic     req_l_valid,
  output logic     req_l_ready,
  output bus_rsp_t rsp_f,
  output logic     rsp_f_valid,
  output bus_rsp_t rsp_l,
  output logic     rsp_l_valid,
  output bus_req_t m_req,
  output axi_id_t  m_id,
  output logic     m_valid,
  input  logic     m_ready,
  input  bus_rsp_t m_rsp,
  input  axi_id_t  m_rsp_id,
  input  logic     m_rsp_valid
);

  logic last_l;  // lsu won the previous grant
  logic pick_f;
  logic pick_l;

  // fetch goes when alone or when lsu had the last turn
  assign pick_f = req_f_valid && (!req_l_valid || last_l);
  assign pick_l = req_l_valid && !pick_f;

  assign req_f_ready = !m_valid && !pick_l;
  assign req_l_ready = !m_valid && !pick_f;

  always_ff @(posedge aclk) begin
    if (rst) begin
      m_valid <= 1'b0;
      last_l  <= 1'b0;
    end else if (m_valid) begin
      if (m_ready) m_valid <= 1'b0;
    end else if (pick_f || pick_l) begin
      m_valid <= 1'b1;
      last_l  <= pick_l;
    end
  end

  always_ff @(posedge aclk) begin
    if (!m_valid && (pick_f || pick_l)) begin
      m_req <= pick_l ? req_l : req_f;
      m_id  <= pick_l ? axi_id_t'(`ID_LSU) : axi_id_t'(`ID_FETCH);
    end
  end

  // route the response back by id
  assign rsp_f       = m_rsp;
  assign rsp_l       = m_rsp;
  assign rsp_f_valid = m_rsp_valid && (m_rsp_id == axi_id_t'(`ID_FETCH));
  assign rsp_l_valid = m_rsp_valid && (m_rsp_id == axi_id_t'(`ID_LSU));

endmodule

`default_nettype wire

// File: source/lsu_port.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_port import core_bus_pkg::*; (
  input  logic      aclk,
  input  logic      rst,
  input  addr_t     ls_addr,
  input  logic      ls_write,
  input  mem_size_e ls_size,
  input  logic      ls_signed,
  input  word_t     ls_wdata,
  input  logic      ls_valid,
  output logic      ls_ready,
  output word_t     ls_rdata,
  output logic      ls_done,
  output logic      ls_err,
  output bus_req_t  req,
  output logic      req_valid,
  input  logic      req_ready,
  input  bus_rsp_t  rsp,
  input  logic      rsp_valid
);

  logic      busy;
  logic [1:0] off_q;
  mem_size_e size_q;
  logic      signed_q;

  // shift the addressed field down and extend it
  function automatic word_t load_extract(word_t data, logic [1:0] off, mem_size_e size,
                                         logic sgn);
    word_t sh;
    sh = data;
    case (size)
      size_byte: begin
        sh = data >> {off, 3'b000};
        return {{24{sgn & sh[7]}}, sh[7:0]};
      end
      size_half: begin
        sh = data >> {off[1], 4'b0000};
        return {{16{sgn & sh[15]}}, sh[15:0]};
      end
      default: return sh;
    endcase
  endfunction

  assign ls_ready = !busy;

  always_ff @(posedge aclk) begin
    if (rst) begin
      busy      <= 1'b0;
      req_valid <= 1'b0;
      ls_done   <= 1'b0;
    end else begin
      ls_done <= 1'b0;
      if (ls_valid && ls_ready) begin
        busy      <= 1'b1;
        req_valid <= 1'b1;
      end else if (req_valid && req_ready) begin
        req_valid <= 1'b0;
      end
      if (busy && rsp_valid) begin
        busy    <= 1'b0;
        ls_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (ls_valid && ls_ready) begin
      req.addr  <= {ls_addr[$bits(addr_t)-1:2], 2'b00};
      req.write <= ls_write;
      off_q     <= ls_addr[1:0];
      size_q    <= ls_size;
      signed_q  <= ls_signed;
      case (ls_size)
        size_byte: begin
          req.wdata <= {4{ls_wdata[7:0]}};
          req.wstrb <= 4'b0001 << ls_addr[1:0];
        end
        size_half: begin
          req.wdata <= {2{ls_wdata[15:0]}};
          req.wstrb <= ls_addr[1] ? 4'b1100 : 4'b0011;
        end
        default: begin
          req.wdata <= ls_wdata;
          req.wstrb <= 4'b1111;
        end
      endcase
      if (!ls_write) req.wstrb <= '0;  // loads carry no strobes
    end
    if (busy && rsp_valid) begin
      ls_rdata <= load_extract(rsp.rdata, off_q, size_q, signed_q);
      ls_err   <= rsp.err;
    end
  end

endmodule

`default_nettype wire

// File: source/fetch_port.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_port import core_bus_pkg::*; (
  input  logic     aclk,
  input  logic     rst,
  input  addr_t    pc,
  input  logic     fetch_valid,
  output logic     fetch_ready,
  output word_t    instr,
  output logic     instr_valid,
  output logic     instr_err,
  output bus_req_t req,
  output logic     req_valid,
  input  logic     req_ready,
  input  bus_rsp_t rsp,
  input  logic     rsp_valid
);

  logic busy;  // read outstanding

  assign fetch_ready = !busy;

  always_ff @(posedge aclk) begin
    if (rst) begin
      busy        <= 1'b0;
      req_valid   <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= 1'b0;
      if (fetch_valid && fetch_ready) begin
        busy      <= 1'b1;
        req_valid <= 1'b1;
      end else if (req_valid && req_ready) begin
        req_valid <= 1'b0;
      end
      if (busy && rsp_valid) begin
        busy        <= 1'b0;
        instr_valid <= 1'b1;  // one cycle pulse
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (fetch_valid && fetch_ready) begin
      req.addr  <= {pc[$bits(addr_t)-1:2], 2'b00};  // word aligned
      req.write <= 1'b0;
      req.wdata <= '0;
      req.wstrb <= '0;
    end
    if (busy && rsp_valid) begin
      instr     <= rsp.rdata;
      instr_err <= rsp.err;
    end
  end

endmodule

`default_nettype wire

// File: source/core_bus_pkg.sv
`default_nettype none

`include "axi_params.svh"

package core_bus_pkg;

  typedef logic [`AXI_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_DATA_W-1:0]   word_t;
  typedef logic [`AXI_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_ID_W-1:0]     axi_id_t;
  typedef logic [1:0]               axi_resp_t;  // 0 is okay

  // encoding follows axsize
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } mem_size_e;

  typedef struct packed {
    axi_id_t    id;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
    logic [1:0] lock;
    logic [3:0] cache;
    logic [2:0] prot;
  } axi_ar_t;

  typedef axi_ar_t axi_aw_t;  // write address carries the same fields

  typedef struct packed {
    word_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

  typedef struct packed {
    axi_id_t   id;
    word_t     data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  typedef struct packed {
    addr_t addr;
    logic  write;
    word_t wdata;
    strb_t wstrb;
  } bus_req_t;

  typedef struct packed {
    word_t rdata;
    logic  err;
  } bus_rsp_t;

endpackage

`default_nettype wire

// File: source/axi_params.svh
`ifndef AXI_PARAMS_SVH
`define AXI_PARAMS_SVH

// bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W   4

// transaction ids, one per requester
`define ID_FETCH 0
`define ID_LSU   1

`endif
